// File: hw/execPkg.sv
`default_nettype none

package execPkg;

    // ************************************************************
    // widths and sizes
    // ************************************************************
    localparam int DATA_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 4;   // 16 registers.
    localparam int ROB_DEPTH      = 8;
    localparam int IMM_WIDTH      = 12;

    typedef logic [REG_ADDR_WIDTH-1:0] regAddr_t;
    typedef logic [2:0] sqN_t;           // wraps, one per rob slot.

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_SLT,     // signed compare.
        OP_ADDI,
        OP_DIV,     // unsigned.
        OP_REM      // unsigned.
    } opcode_t;

    // ************************************************************
    // micro-op word, two views of the same 24 bits
    // ************************************************************
    typedef struct packed {
        opcode_t   opcode;
        regAddr_t  dst;
        regAddr_t  srcA;
        regAddr_t  srcB;
        logic [7:0] unused;
    } rForm_t;

    typedef struct packed {
        opcode_t   opcode;
        regAddr_t  dst;
        regAddr_t  srcA;
        logic [IMM_WIDTH-1:0] imm;  // signed.
    } iForm_t;

    typedef union packed {
        rForm_t rForm;
        iForm_t iForm;
    } uopWord_t;

endpackage

`default_nettype wire

// File: hw/dispatchStage.sv
`timescale 1ns/1ns
`default_nettype none

module dispatchStage #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH,
    parameter int ROB_DEPTH  = execPkg::ROB_DEPTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic inReq,
    output logic inAck,
    input  execPkg::uopWord_t inUop,
    output execPkg::regAddr_t srcAAddr,
    output execPkg::regAddr_t srcBAddr,
    input  logic [DATA_WIDTH-1:0] srcAData,
    input  logic [DATA_WIDTH-1:0] srcBData,
    input  logic [(2**execPkg::REG_ADDR_WIDTH)-1:0] pendingMask,
    input  logic robFull,
    input  logic divBusy,
    output logic issueValid,
    output logic issueIsDiv,
    output execPkg::sqN_t issueSqN,
    output execPkg::opcode_t issueOp,
    output execPkg::regAddr_t issueDst,
    output logic [DATA_WIDTH-1:0] opA,
    output logic [DATA_WIDTH-1:0] opB
);
    import execPkg::*;

    logic isImm;
    logic hazard;
    sqN_t sqNCnt;

    assign issueOp    = inUop.rForm.opcode;
    assign isImm      = (issueOp == OP_ADDI);
    assign issueIsDiv = (issueOp == OP_DIV) || (issueOp == OP_REM);
    assign issueDst   = inUop.rForm.dst;
    assign srcAAddr   = inUop.rForm.srcA;
    assign srcBAddr   = inUop.rForm.srcB;

    // srcB is a don't-care in immediate form.
    assign hazard = pendingMask[srcAAddr] || (!isImm && pendingMask[srcBAddr]) ||
                    pendingMask[issueDst];

    assign issueValid = inReq && !inAck && !hazard && !robFull && !(issueIsDiv && divBusy);
    assign issueSqN   = sqNCnt;
    assign opA        = srcAData;
    assign opB        = isImm ? {{(DATA_WIDTH-IMM_WIDTH){inUop.iForm.imm[IMM_WIDTH-1]}},
                                 inUop.iForm.imm} : srcBData;

    // four-phase accept, ack follows issue by one cycle.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            inAck  <= 1'b0;
            sqNCnt <= '0;
        end else if (issueValid) begin
            inAck  <= 1'b1;
            sqNCnt <= (sqNCnt == sqN_t'(ROB_DEPTH - 1)) ? '0 : sqNCnt + 1'b1;
        end else if (inAck && !inReq) begin
            inAck <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH
) (
    input  logic clk,
    input  logic rstN,
    input  execPkg::regAddr_t srcAAddr,
    input  execPkg::regAddr_t srcBAddr,
    output logic [DATA_WIDTH-1:0] srcAData,
    output logic [DATA_WIDTH-1:0] srcBData,
    input  logic setPending,
    input  execPkg::regAddr_t setDst,
    input  logic wbValid,
    input  execPkg::regAddr_t wbDst,
    input  logic [DATA_WIDTH-1:0] wbResult,
    output logic [(2**execPkg::REG_ADDR_WIDTH)-1:0] pendingMask
);
    import execPkg::*;

    localparam int NUM_REGS = 2**REG_ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            pendingMask <= '0;
        end else begin
            if (wbValid) begin
                regs[wbDst]        <= wbResult;
                pendingMask[wbDst] <= 1'b0;
            end
            if (setPending) pendingMask[setDst] <= 1'b1; // never the wb reg.
        end
    end

    assign srcAData = regs[srcAAddr];
    assign srcBData = regs[srcBAddr];

endmodule

`default_nettype wire

// File: hw/intAlu.sv
`timescale 1ns/1ns
`default_nettype none

module intAlu #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  logic issueIsDiv,
    input  execPkg::opcode_t issueOp,
    input  execPkg::sqN_t issueSqN,
    input  execPkg::regAddr_t issueDst,
    input  logic [DATA_WIDTH-1:0] opA,
    input  logic [DATA_WIDTH-1:0] opB,
    input  logic divDone,
    input  execPkg::sqN_t divSqN,
    input  execPkg::regAddr_t divDst,
    input  logic [DATA_WIDTH-1:0] divResult,
    output logic divGrant,
    output logic wbValid,
    output execPkg::sqN_t wbSqN,
    output execPkg::regAddr_t wbDst,
    output logic [DATA_WIDTH-1:0] wbResult
);
    import execPkg::*;

    logic aluValid;
    sqN_t aluSqN;
    regAddr_t aluDst;
    logic [DATA_WIDTH-1:0] aluResult;
    logic [DATA_WIDTH-1:0] aluNext;

    always_comb begin
        case (issueOp)
            OP_ADD, OP_ADDI: aluNext = opA + opB;
            OP_SUB:          aluNext = opA - opB;
            OP_AND:          aluNext = opA & opB;
            OP_XOR:          aluNext = opA ^ opB;
            OP_SLT:          aluNext = {{(DATA_WIDTH-1){1'b0}}, ($signed(opA) < $signed(opB))};
            default:         aluNext = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) aluValid <= 1'b0;
        else       aluValid <= issueValid && !issueIsDiv;
    end

    always_ff @(posedge clk) begin
        aluSqN    <= issueSqN;
        aluDst    <= issueDst;
        aluResult <= aluNext;
    end

    // ************************************************************
    // shared writeback lane, alu first
    // ************************************************************
    assign divGrant = divDone && !aluValid;
    assign wbValid  = aluValid || divDone;
    assign wbSqN    = aluValid ? aluSqN : divSqN;
    assign wbDst    = aluValid ? aluDst : divDst;
    assign wbResult = aluValid ? aluResult : divResult;

endmodule

`default_nettype wire

// File: hw/serialDivider.sv
`timescale 1ns/1ns
`default_nettype none

module serialDivider #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  logic issueIsDiv,
    input  execPkg::opcode_t issueOp,
    input  execPkg::sqN_t issueSqN,
    input  execPkg::regAddr_t issueDst,
    input  logic [DATA_WIDTH-1:0] opA,
    input  logic [DATA_WIDTH-1:0] opB,
    input  logic divGrant,
    output logic divBusy,
    output logic divDone,
    output execPkg::sqN_t divSqN,
    output execPkg::regAddr_t divDst,
    output logic [DATA_WIDTH-1:0] divResult
);
    import execPkg::*;

    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic [CNT_W-1:0] stepCnt;
    logic [DATA_WIDTH-1:0] quo;
    logic [DATA_WIDTH-1:0] rem;
    logic [DATA_WIDTH-1:0] divisor;
    logic isRem;
    logic [DATA_WIDTH:0] shifted;
    logic [DATA_WIDTH:0] diff;

    assign shifted   = {rem, quo[DATA_WIDTH-1]};
    assign diff      = shifted - {1'b0, divisor};   // msb set means it did not fit.
    assign divResult = isRem ? rem : quo;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            divBusy <= 1'b0;
            divDone <= 1'b0;
            stepCnt <= '0;
        end else if (issueValid && issueIsDiv) begin
            divBusy <= 1'b1;
            stepCnt <= CNT_W'(DATA_WIDTH);
        end else if (divDone) begin
            if (divGrant) begin
                divBusy <= 1'b0;
                divDone <= 1'b0;
            end
        end else if (divBusy) begin
            stepCnt <= stepCnt - 1'b1;
            if (stepCnt == CNT_W'(1)) divDone <= 1'b1;
        end
    end

    // restoring loop; a zero divisor always fits, giving all ones.
    always_ff @(posedge clk) begin
        if (issueValid && issueIsDiv) begin
            quo     <= opA;
            rem     <= '0;
            divisor <= opB;
            isRem   <= (issueOp == OP_REM);
            divSqN  <= issueSqN;
            divDst  <= issueDst;
        end else if (divBusy && !divDone) begin
            rem <= diff[DATA_WIDTH] ? shifted[DATA_WIDTH-1:0] : diff[DATA_WIDTH-1:0];
            quo <= {quo[DATA_WIDTH-2:0], !diff[DATA_WIDTH]};
        end
    end

endmodule

`default_nettype wire

// File: hw/reorderBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module reorderBuffer #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH,
    parameter int ROB_DEPTH  = execPkg::ROB_DEPTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic issueValid,
    input  execPkg::sqN_t issueSqN,
    input  execPkg::regAddr_t issueDst,
    output logic robFull,
    input  logic wbValid,
    input  execPkg::sqN_t wbSqN,
    input  logic [DATA_WIDTH-1:0] wbResult,
    output logic outReq,
    input  logic outAck,
    output execPkg::sqN_t outSqN,
    output execPkg::regAddr_t outDst,
    output logic [DATA_WIDTH-1:0] outResult
);
    import execPkg::*;

    sqN_t headPtr;
    sqN_t tailPtr;
    logic [ROB_DEPTH-1:0] entryBusy;
    logic [ROB_DEPTH-1:0] entryDone;
    regAddr_t dstMem [ROB_DEPTH];
    logic [DATA_WIDTH-1:0] resultMem [ROB_DEPTH];

    function automatic sqN_t nextPtr(input sqN_t p);
        return (p == sqN_t'(ROB_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // slot under tail still waiting to retire.
    assign robFull   = entryBusy[tailPtr];
    assign outSqN    = headPtr;
    assign outDst    = dstMem[headPtr];
    assign outResult = resultMem[headPtr];

    // ************************************************************
    // allocate, complete, retire
    // ************************************************************
    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr   <= '0;
            tailPtr   <= '0;
            entryBusy <= '0;
            entryDone <= '0;
            outReq    <= 1'b0;
        end else begin
            if (issueValid) begin
                entryBusy[issueSqN] <= 1'b1;
                entryDone[issueSqN] <= 1'b0;
                tailPtr             <= nextPtr(tailPtr);
            end
            if (wbValid) entryDone[wbSqN] <= 1'b1;

            if (outReq && outAck) begin
                outReq             <= 1'b0;
                entryBusy[headPtr] <= 1'b0;
                entryDone[headPtr] <= 1'b0;
                headPtr            <= nextPtr(headPtr);
            end else if (!outReq && !outAck && entryDone[headPtr]) begin
                outReq <= 1'b1;     // wait for ack low first.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueValid) dstMem[issueSqN] <= issueDst;
        if (wbValid) resultMem[wbSqN] <= wbResult;
    end

endmodule

`default_nettype wire

// File: hw/execCluster.sv
`timescale 1ns/1ns
`default_nettype none

module execCluster #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH,
    parameter int ROB_DEPTH  = execPkg::ROB_DEPTH
) (
    input  logic clk,
    input  logic rstN,
    input  logic inReq,
    output logic inAck,
    input  execPkg::uopWord_t inUop,
    output logic outReq,
    input  logic outAck,
    output execPkg::sqN_t outSqN,
    output execPkg::regAddr_t outDst,
    output logic [DATA_WIDTH-1:0] outResult
);
    import execPkg::*;

    regAddr_t srcAAddr;
    regAddr_t srcBAddr;
    logic [DATA_WIDTH-1:0] srcAData;
    logic [DATA_WIDTH-1:0] srcBData;
    logic [(2**REG_ADDR_WIDTH)-1:0] pendingMask;
    logic robFull;
    logic divBusy;
    logic issueValid;
    logic issueIsDiv;
    sqN_t issueSqN;
    opcode_t issueOp;
    regAddr_t issueDst;
    logic [DATA_WIDTH-1:0] opA;
    logic [DATA_WIDTH-1:0] opB;
    logic divDone;
    logic divGrant;
    sqN_t divSqN;
    regAddr_t divDst;
    logic [DATA_WIDTH-1:0] divResult;
    logic wbValid;
    sqN_t wbSqN;
    regAddr_t wbDst;
    logic [DATA_WIDTH-1:0] wbResult;

    dispatchStage #(.DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH)) dispatch
    (
        .clk(clk), .rstN(rstN),
        .inReq(inReq), .inAck(inAck), .inUop(inUop),
        .srcAAddr(srcAAddr), .srcBAddr(srcBAddr),
        .srcAData(srcAData), .srcBData(srcBData),
        .pendingMask(pendingMask), .robFull(robFull), .divBusy(divBusy),
        .issueValid(issueValid), .issueIsDiv(issueIsDiv), .issueSqN(issueSqN),
        .issueOp(issueOp), .issueDst(issueDst), .opA(opA), .opB(opB)
    );

    regFile #(.DATA_WIDTH(DATA_WIDTH)) rf
    (
        .clk(clk), .rstN(rstN),
        .srcAAddr(srcAAddr), .srcBAddr(srcBAddr),
        .srcAData(srcAData), .srcBData(srcBData),
        .setPending(issueValid), .setDst(issueDst),
        .wbValid(wbValid), .wbDst(wbDst), .wbResult(wbResult),
        .pendingMask(pendingMask)
    );

    // ************************************************************
    // functional units, merged onto one writeback lane
    // ************************************************************
    intAlu #(.DATA_WIDTH(DATA_WIDTH)) ialu
    (
        .clk(clk), .rstN(rstN),
        .issueValid(issueValid), .issueIsDiv(issueIsDiv), .issueOp(issueOp),
        .issueSqN(issueSqN), .issueDst(issueDst), .opA(opA), .opB(opB),
        .divDone(divDone), .divSqN(divSqN), .divDst(divDst), .divResult(divResult),
        .divGrant(divGrant),
        .wbValid(wbValid), .wbSqN(wbSqN), .wbDst(wbDst), .wbResult(wbResult)
    );

    serialDivider #(.DATA_WIDTH(DATA_WIDTH)) div
    (
        .clk(clk), .rstN(rstN),
        .issueValid(issueValid), .issueIsDiv(issueIsDiv), .issueOp(issueOp),
        .issueSqN(issueSqN), .issueDst(issueDst), .opA(opA), .opB(opB),
        .divGrant(divGrant), .divBusy(divBusy), .divDone(divDone),
        .divSqN(divSqN), .divDst(divDst), .divResult(divResult)
    );

    reorderBuffer #(.DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH)) rob
    (
        .clk(clk), .rstN(rstN),
        .issueValid(issueValid), .issueSqN(issueSqN), .issueDst(issueDst),
        .robFull(robFull),
        .wbValid(wbValid), .wbSqN(wbSqN), .wbResult(wbResult),
        .outReq(outReq), .outAck(outAck),
        .outSqN(outSqN), .outDst(outDst), .outResult(outResult)
    );

endmodule

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge.
    initial begin
        rstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// File: verification/execClusterAsserts.sv
`timescale 1ns/1ns
`default_nettype none

module execClusterAsserts (
    input logic clk,
    input logic rstN,
    input logic inReq,
    input logic inAck,
    input logic outReq,
    input logic outAck
);

    int failCount = 0;

    outReqHeld: assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> outReq)
        else begin
            failCount++;
            $error("outReq dropped before outAck was seen");
        end

    // ack only answers a request that is or was there.
    inAckAnswers: assert property (@(posedge clk) disable iff (!rstN)
        inAck |-> (inReq || $past(inReq)))
        else begin
            failCount++;
            $error("inAck high without an input request");
        end

    outReqAfterAckLow: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outReq) |-> !$past(outAck))
        else begin
            failCount++;
            $error("outReq raised while outAck was still high");
        end

endmodule

`default_nettype wire

// File: verification/resultChecker.sv
`timescale 1ns/1ns
`default_nettype none

module resultChecker #(
    parameter int DATA_WIDTH = execPkg::DATA_WIDTH,
    parameter int ROB_DEPTH  = execPkg::ROB_DEPTH,
    parameter int NUM_TESTS  = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic outReq,
    input  execPkg::sqN_t outSqN,
    input  execPkg::regAddr_t outDst,
    input  logic [DATA_WIDTH-1:0] outResult,
    input  execPkg::uopWord_t uopTable [NUM_TESTS],
    input  execPkg::regAddr_t expDst [NUM_TESTS],
    input  logic [DATA_WIDTH-1:0] expResult [NUM_TESTS],
    output int errorCount,
    output int commitCount
);
    import execPkg::*;

    logic lastReq = 1'b0;

    function automatic string opName(input opcode_t op);
        case (op)
            OP_ADD:  return "add";
            OP_SUB:  return "sub";
            OP_AND:  return "and";
            OP_XOR:  return "xor";
            OP_SLT:  return "slt";
            OP_ADDI: return "addi";
            OP_DIV:  return "div";
            OP_REM:  return "rem";
            default: return "unknown";
        endcase
    endfunction

    task automatic compareValue(input string name, input string field,
                                input logic [DATA_WIDTH-1:0] expected,
                                input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("Error: test %s %s expected %h actual %h", name, field, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkCommit();
        string name;
        if (commitCount >= NUM_TESTS) begin
            $display("Error: an extra result was committed after the last entry, sqN %0d",
                     outSqN);
            errorCount++;
        end else begin
            name = $sformatf("%0d_%s", commitCount, opName(uopTable[commitCount].rForm.opcode));
            compareValue(name, "sqN", DATA_WIDTH'(commitCount % ROB_DEPTH), DATA_WIDTH'(outSqN));
            compareValue(name, "dst", DATA_WIDTH'(expDst[commitCount]), DATA_WIDTH'(outDst));
            compareValue(name, "result", expResult[commitCount], outResult);
        end
        commitCount++;
    endtask

    initial begin
        errorCount  = 0;
        commitCount = 0;
    end

    // ************************************************************
    // one commit per rising edge of outReq
    // ************************************************************
    always @(negedge clk) begin
        if (rstN && outReq && !lastReq) checkCommit();
        lastReq = outReq;
    end

endmodule

`default_nettype wire

// File: verification/execClusterTb.sv
`timescale 1ns/1ns
`default_nettype none

module execClusterTb;
    import execPkg::*;

    localparam int DATA_WIDTH    = 32;
    localparam int ROB_DEPTH     = 8;
    localparam int CLK_PERIOD    = 4;
    localparam int NUM_TESTS     = 15;
    localparam int SETTLE_CYCLES = 20;
    localparam int TIMEOUT_NS    = NUM_TESTS * (DATA_WIDTH + 16) * CLK_PERIOD * 4;

    logic clk;
    logic rstN;
    logic inReq;
    logic inAck;
    uopWord_t inUop;
    logic outReq;
    logic outAck;
    sqN_t outSqN;
    regAddr_t outDst;
    logic [DATA_WIDTH-1:0] outResult;

    uopWord_t uopTable [NUM_TESTS];
    regAddr_t expDst [NUM_TESTS];
    logic [DATA_WIDTH-1:0] expResult [NUM_TESTS];

    int errorCount;
    int commitCount;
    int assertFails;
    int ackDelay;
    integer seed = 32'h6705_00ad;

    function automatic uopWord_t makeRForm(input opcode_t op, input regAddr_t dst,
                                           input regAddr_t a, input regAddr_t b);
        uopWord_t w;
        w.rForm.opcode = op;
        w.rForm.dst    = dst;
        w.rForm.srcA   = a;
        w.rForm.srcB   = b;
        w.rForm.unused = '0;
        return w;
    endfunction

    function automatic uopWord_t makeIForm(input opcode_t op, input regAddr_t dst,
                                           input regAddr_t a, input logic [IMM_WIDTH-1:0] imm);
        uopWord_t w;
        w.iForm.opcode = op;
        w.iForm.dst    = dst;
        w.iForm.srcA   = a;
        w.iForm.imm    = imm;
        return w;
    endfunction

    task automatic setEntry(input int idx, input uopWord_t word, input regAddr_t dst,
                            input logic [DATA_WIDTH-1:0] result);
        uopTable[idx]  = word;
        expDst[idx]    = dst;
        expResult[idx] = result;
    endtask

    // ************************************************************
    // stimulus table over registers that start at zero
    // ************************************************************
    task automatic loadTable();
        setEntry(0,  makeIForm(OP_ADDI, 4'd1, 4'd0, 12'h064), 4'd1, 32'h0000_0064);
        setEntry(1,  makeIForm(OP_ADDI, 4'd2, 4'd0, 12'hFF9), 4'd2, 32'hFFFF_FFF9); // -7.
        setEntry(2,  makeRForm(OP_ADD, 4'd3, 4'd1, 4'd2), 4'd3, 32'h0000_005D);
        setEntry(3,  makeRForm(OP_SUB, 4'd4, 4'd2, 4'd1), 4'd4, 32'hFFFF_FF95);
        setEntry(4,  makeRForm(OP_AND, 4'd5, 4'd1, 4'd2), 4'd5, 32'h0000_0060);
        setEntry(5,  makeRForm(OP_XOR, 4'd6, 4'd1, 4'd2), 4'd6, 32'hFFFF_FF9D);
        setEntry(6,  makeRForm(OP_SLT, 4'd7, 4'd2, 4'd1), 4'd7, 32'h0000_0001);
        setEntry(7,  makeRForm(OP_SLT, 4'd8, 4'd1, 4'd2), 4'd8, 32'h0000_0000);
        setEntry(8,  makeRForm(OP_DIV, 4'd9, 4'd2, 4'd1), 4'd9, 32'h028F_5C28);
        // independent add overtakes the divide, then waits in the rob.
        setEntry(9,  makeRForm(OP_ADD, 4'd11, 4'd3, 4'd4), 4'd11, 32'hFFFF_FFF2);
        setEntry(10, makeIForm(OP_ADDI, 4'd12, 4'd9, 12'h001), 4'd12, 32'h028F_5C29);
        setEntry(11, makeRForm(OP_REM, 4'd10, 4'd2, 4'd1), 4'd10, 32'h0000_0059);
        setEntry(12, makeRForm(OP_DIV, 4'd13, 4'd1, 4'd0), 4'd13, 32'hFFFF_FFFF); // by zero.
        setEntry(13, makeRForm(OP_REM, 4'd14, 4'd1, 4'd0), 4'd14, 32'h0000_0064);
        setEntry(14, makeRForm(OP_SUB, 4'd15, 4'd10, 4'd14), 4'd15, 32'hFFFF_FFF5);
    endtask

    task automatic sendUop(input uopWord_t word);
        @(negedge clk);
        inUop = word;
        inReq = 1'b1;
        @(negedge clk);
        while (!inAck) @(negedge clk);
        inReq = 1'b0;
        @(negedge clk);
        while (inAck) @(negedge clk);
    endtask

    clockGen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) clockGen_i (.clk(clk), .rstN(rstN));

    execCluster #(.DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH)) execCluster_i (
        .clk(clk), .rstN(rstN),
        .inReq(inReq), .inAck(inAck), .inUop(inUop),
        .outReq(outReq), .outAck(outAck),
        .outSqN(outSqN), .outDst(outDst), .outResult(outResult)
    );

    resultChecker #(.DATA_WIDTH(DATA_WIDTH), .ROB_DEPTH(ROB_DEPTH), .NUM_TESTS(NUM_TESTS))
        resultChecker_i (
        .clk(clk), .rstN(rstN), .outReq(outReq),
        .outSqN(outSqN), .outDst(outDst), .outResult(outResult),
        .uopTable(uopTable), .expDst(expDst), .expResult(expResult),
        .errorCount(errorCount), .commitCount(commitCount)
    );

    bind execCluster execClusterAsserts handshakeAsserts (
        .clk(clk), .rstN(rstN), .inReq(inReq), .inAck(inAck),
        .outReq(outReq), .outAck(outAck)
    );

    initial begin
        inReq = 1'b0;
        inUop = '0;
        loadTable();
        @(posedge rstN);
        for (int i = 0; i < NUM_TESTS; i++) begin
            sendUop(uopTable[i]);
        end
        while (commitCount < NUM_TESTS) @(negedge clk);
        repeat (SETTLE_CYCLES) @(negedge clk);  // room for a duplicate commit.
        assertFails = execCluster_i.handshakeAsserts.failCount;
        $display("commits %0d of %0d, errors %0d, assertion failures %0d",
                 commitCount, NUM_TESTS, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0 && commitCount == NUM_TESTS) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // output side acks after a random delay.
    initial begin
        outAck = 1'b0;
        forever begin
            @(negedge clk);
            if (outReq) begin
                ackDelay = $unsigned($random(seed)) % 6;
                repeat (ackDelay) @(negedge clk);
                outAck = 1'b1;
                while (outReq) @(negedge clk);
                ackDelay = $unsigned($random(seed)) % 3;  // ack may linger past outReq.
                repeat (ackDelay) @(negedge clk);
                outAck = 1'b0;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: only %0d of %0d entries committed within %0d ns",
                 commitCount, NUM_TESTS, TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/execPkg.sv
hw/dispatchStage.sv
hw/regFile.sv
hw/intAlu.sv
hw/serialDivider.sv
hw/reorderBuffer.sv
hw/execCluster.sv
verification/clockGen.sv
verification/execClusterAsserts.sv
verification/resultChecker.sv
verification/execClusterTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
        --top-module execClusterTb -o execClusterSim -f compile.f \
    && ./obj_dir/execClusterSim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "RUN PASS" \
    || { echo "RUN FAIL"; exit 1; }
